//--- source/vtl_video_pkg.sv
/* video timing, border geometry and palette of the Laser 500 video chip
   also the display mode type shared by fetch and register logic */
`default_nettype none

package vtl_video_pkg;

	// horizontal timing, pixel clocks
	localparam int H_FP      = 10;  // front porch
	localparam int H_SW      = 66;  // hsync width
	localparam int H_BP      = 78;  // back porch
	localparam int H_VISIBLE = 798;
	localparam int H_TOTAL   = H_SW + H_BP + H_VISIBLE + H_FP;  // 952

	localparam int LEFT_BORDER  = 72;
	localparam int ACTIVE_WIDTH = 640;

	// vertical timing, lines
	localparam int TOP_BORDER    = 68;
	localparam int ACTIVE_HEIGHT = 192;
	localparam int V_SYNC_LINES  = 2;
	localparam int V_TOTAL       = 312;

	localparam int ACTIVE_START = H_SW + H_BP + LEFT_BORDER;  // first active hcnt

	// row address loaded this many pixels ahead of the active area
	localparam int LOAD_LEAD_TEXT40 = 16;  // char + attribute pair
	localparam int LOAD_LEAD_NARROW = 8;

	localparam int CNT_W      = 10;
	localparam int VRAM_AW    = 14;
	localparam int CHARSET_AW = 13;

	typedef logic [3:0] color_idx_t;

	typedef enum logic [1:0] {MODE_TEXT40, MODE_TEXT80, MODE_GR5} vdc_mode_e;

	// 12-bit rgb, 4 bits per gun
	localparam logic [11:0] PALETTE [16] = '{
		12'h000, 12'h00f, 12'h080, 12'h09f,  // black blue green cyan
		12'h600, 12'h83f, 12'h780, 12'hccc,  // red magenta yellow grey
		12'h667, 12'h88f, 12'h5e3, 12'h8cf,  // dark grey, bright blue/green/cyan
		12'hf59, 12'hf9f, 12'hee6, 12'hfff   // bright red/magenta/yellow, white
	};

endpackage

`default_nettype wire

//--- source/vtl_bus_pkg.sv
/* bus slot numbering, Z80 port numbers and SDRAM page map */
`default_nettype none

package vtl_bus_pkg;

	typedef logic [3:0] page_t;

	// 3-bit slot counter, bit 2 low = video owns the bus
	localparam logic [2:0] SLOT_CPU_START = 3'd3;  // sample MREQ_n here
	localparam logic [2:0] SLOT_CPU_ENA   = 3'd4;
	localparam logic [2:0] SLOT_CPU_END   = 3'd7;  // release wait, latch data

	// z80 io ports
	localparam logic [7:0] PORT_BANK0     = 8'h40;
	localparam logic [7:0] PORT_BANK1     = 8'h41;
	localparam logic [7:0] PORT_BANK2     = 8'h42;
	localparam logic [7:0] PORT_BANK3     = 8'h43;
	localparam logic [7:0] PORT_VDC_CTRL  = 8'h44;  // border, page, text80
	localparam logic [7:0] PORT_VDC_COLOR = 8'h45;  // text fg/bg

	// memory mapped io window inside page 2
	localparam logic [13:0] MAPPED_IO_LO   = 14'h2800;
	localparam logic [13:0] MAPPED_IO_HI   = 14'h2FFF;
	localparam page_t       PAGE_MAPPED_IO = 4'd2;

	localparam page_t PAGE_RAM_LO = 4'd4;  // writable pages
	localparam page_t PAGE_RAM_HI = 4'd7;

	localparam page_t VIDEO_PAGE_HI = 4'd7;  // laser 500/700
	localparam page_t VIDEO_PAGE_LO = 4'd3;  // laser 350

	localparam int SDRAM_AW = 25;

endpackage

`default_nettype wire

//--- source/vtl_raster_counters.sv
/* raster counters for the 952 x 312 frame
   negative syncs plus blanking and border flags */
`timescale 1ns/1ps
`default_nettype none

module vtl_raster_counters import vtl_video_pkg::*; (
	input  logic             F14M,
	input  logic             RESET,
	output logic [CNT_W-1:0] hcnt,      // pixel in line
	output logic [CNT_W-1:0] vcnt,      // line in frame
	output logic [CNT_W-1:0] ycnt,      // line in active area
	output logic             hsync,
	output logic             vsync,
	output logic             in_blank,
	output logic             in_border
);

	logic line_end;

	assign line_end = (hcnt == H_TOTAL - 1);

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
			ycnt <= '0;
		end else begin
			if (line_end) begin
				hcnt <= '0;
				if (vcnt == V_TOTAL - 1)
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
				// restart on last top border line, so first active line is 0
				if (vcnt == TOP_BORDER - 1)
					ycnt <= '0;
				else
					ycnt <= ycnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	assign hsync = !(hcnt < H_SW);          // active low
	assign vsync = !(vcnt < V_SYNC_LINES);

	// porches and sync lines are black
	assign in_blank = (hcnt < H_SW + H_BP) || (hcnt >= H_SW + H_BP + H_VISIBLE)
		|| (vcnt < V_SYNC_LINES);

	// anything outside the 640x192 window
	assign in_border = (vcnt < TOP_BORDER) || (vcnt >= TOP_BORDER + ACTIVE_HEIGHT)
		|| (hcnt < ACTIVE_START) || (hcnt >= ACTIVE_START + ACTIVE_WIDTH);

endmodule

`default_nettype wire

//--- source/vtl_io_registers.sv
/* bank table and video control registers written by the Z80 */
`timescale 1ns/1ps
`default_nettype none

module vtl_io_registers import vtl_video_pkg::*, vtl_bus_pkg::*; (
	input  logic       F14M,
	input  logic       RESET,
	input  logic       IORQ_n,
	input  logic       WR_n,
	input  logic       cpu_io_write,   // mapped io write pulse from arbiter
	input  logic [7:0] A_low,
	input  logic [7:0] DO,
	output page_t      banks [4],
	output vdc_mode_e  mode,
	output color_idx_t border_color,
	output color_idx_t text_fg,
	output color_idx_t text_bg,
	output logic       video_page_hi
);

	logic text80;     // 0x44 bit 0
	logic gr_enable;  // mapped io bit 3

	always_ff @(posedge F14M) begin
		if (RESET) begin
			banks         <= '{default: '0};
			border_color  <= 4'd9;
			text_fg       <= 4'd15;
			text_bg       <= 4'd1;
			video_page_hi <= 1'b1;
			text80        <= 1'b0;
			gr_enable     <= 1'b0;
		end else begin
			if (!IORQ_n && !WR_n) begin  // port write
				case (A_low)
					PORT_BANK0: banks[0] <= DO[3:0];
					PORT_BANK1: banks[1] <= DO[3:0];
					PORT_BANK2: banks[2] <= DO[3:0];
					PORT_BANK3: banks[3] <= DO[3:0];
					PORT_VDC_CTRL: begin
						border_color  <= DO[7:4];
						video_page_hi <= !DO[3];  // bit set selects page 3
						text80        <= DO[0];
					end
					PORT_VDC_COLOR: begin
						text_fg <= DO[7:4];
						text_bg <= DO[3:0];
					end
					default: ;  // printer, floppy etc not present
				endcase
			end
			if (cpu_io_write)
				gr_enable <= DO[3];
		end
	end

	// any graphic enable means gr5, other codes had no hardware left
	always_comb begin
		if (gr_enable)
			mode = MODE_GR5;
		else if (text80)
			mode = MODE_TEXT80;
		else
			mode = MODE_TEXT40;
	end

endmodule

`default_nettype wire

//--- source/vtl_bus_arbiter.sv
/* 8-slot bus sharing between video fetch and Z80
   generates CPU clock/enable, wait states and the SDRAM mux */
`timescale 1ns/1ps
`default_nettype none

module vtl_bus_arbiter import vtl_video_pkg::*, vtl_bus_pkg::*; (
	input  logic                F14M,
	input  logic                RESET,
	input  logic                MREQ_n,
	input  logic                IORQ_n,
	input  logic                RD_n,
	input  logic                WR_n,
	input  logic [15:0]         A,
	input  logic [7:0]          DO,
	input  page_t               banks [4],
	input  logic                video_page_hi,
	input  logic [VRAM_AW-1:0]  video_addr,
	input  logic                video_cs,
	input  logic [7:0]          sdram_dout,
	output logic                CPUCK,
	output logic                CPUENA,
	output logic                WAIT_n,
	output logic [7:0]          DI,
	output logic                cpu_io_write,
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [7:0]          sdram_din,
	output logic                sdram_wr,
	output logic                sdram_cs
);

	logic [2:0] slot;
	logic       cv;        // 1 = video half
	logic       cpu_cs;
	page_t      cpu_page;
	page_t      video_page;
	logic       mapped_io;
	logic       bank_is_ram;

	assign cv       = ~slot[2];
	assign CPUCK    = slot[1];  // F14M / 4
	assign CPUENA   = (slot == SLOT_CPU_ENA);
	assign cpu_page = banks[A[15:14]];

	assign mapped_io = (cpu_page == PAGE_MAPPED_IO)
		&& (A[13:0] >= MAPPED_IO_LO) && (A[13:0] <= MAPPED_IO_HI);
	assign bank_is_ram = (cpu_page >= PAGE_RAM_LO) && (cpu_page <= PAGE_RAM_HI);

	always_ff @(posedge F14M) begin
		if (RESET) begin
			slot         <= '0;
			WAIT_n       <= 1'b1;
			cpu_cs       <= 1'b0;
			cpu_io_write <= 1'b0;
		end else begin
			slot         <= slot + 1'b1;
			cpu_io_write <= 1'b0;  // one cycle pulse
			if (slot == SLOT_CPU_START && !MREQ_n) begin
				WAIT_n       <= 1'b0;  // hold cpu for slots 4..7
				cpu_cs       <= 1'b1;
				cpu_io_write <= !WR_n && mapped_io;
			end
			if (slot == SLOT_CPU_END && !WAIT_n) begin
				WAIT_n <= 1'b1;
				cpu_cs <= 1'b0;
			end
		end
	end

	// payload latches
	always_ff @(posedge F14M) begin
		if (slot == SLOT_CPU_START && !MREQ_n && !WR_n)
			sdram_din <= DO;
		if (slot == SLOT_CPU_END && !WAIT_n && !RD_n)
			DI <= sdram_dout;
		else if (!IORQ_n && !RD_n)
			DI <= 8'h00;  // io reads not implemented, as on the original
	end

	assign video_page = video_page_hi ? VIDEO_PAGE_HI : VIDEO_PAGE_LO;

	assign sdram_addr = cv ? {{(SDRAM_AW - 18){1'b0}}, video_page, video_addr}
		: {{(SDRAM_AW - 18){1'b0}}, cpu_page, A[13:0]};
	assign sdram_wr = !cv && !MREQ_n && !WR_n && bank_is_ram;  // rom pages read only
	assign sdram_cs = cpu_cs | video_cs;

endmodule

`default_nettype wire

//--- source/vtl_pixel_fetch.sv
/* video RAM fetch, charset lookup and pixel shifter
   TEXT40, TEXT80 and GR5 with border and blanking */
`timescale 1ns/1ps
`default_nettype none

module vtl_pixel_fetch import vtl_video_pkg::*; (
	input  logic                  F14M,
	input  logic                  RESET,
	input  logic [CNT_W-1:0]      hcnt,
	input  logic [CNT_W-1:0]      ycnt,
	input  logic                  in_blank,
	input  logic                  in_border,
	input  vdc_mode_e             mode,
	input  color_idx_t            border_color,
	input  color_idx_t            text_fg,
	input  color_idx_t            text_bg,
	input  logic [7:0]            sdram_dout,
	input  logic [7:0]            charset_q,
	output logic [VRAM_AW-1:0]    video_addr,
	output logic                  video_cs,
	output logic [CHARSET_AW-1:0] charset_addr,
	output color_idx_t            pixel
);

	logic [CNT_W-1:0]   xcnt;         // x relative to active start
	logic [CNT_W-1:0]   load_column;  // hcnt where row address loads
	logic [VRAM_AW-1:0] row_addr;
	logic [7:0]         ram_data;     // byte latched at phase 3
	logic [7:0]         char_d;       // text40 charset byte waiting for attr
	logic [7:0]         char_sr;      // shifter, lsb first
	logic [7:0]         fgbg;         // text40 attribute
	color_idx_t         fg;
	color_idx_t         bg;

	assign xcnt = hcnt - CNT_W'(ACTIVE_START);

	assign load_column = (mode == MODE_TEXT40) ? CNT_W'(ACTIVE_START - 1 - LOAD_LEAD_TEXT40)
		: CNT_W'(ACTIVE_START - 1 - LOAD_LEAD_NARROW);

	// text page at 0x3800, gr5 lines interleaved by ycnt[2:0]; row * 80 via bits 7:6 twice
	assign row_addr = {(mode == MODE_GR5) ? ycnt[2:0] : 3'b111,
		ycnt[5:3], ycnt[7:6], ycnt[7:6], 4'b0000};

	assign fg = (mode == MODE_TEXT40) ? fgbg[7:4] : text_fg;
	assign bg = (mode == MODE_TEXT40) ? fgbg[3:0] : text_bg;

	// address and strobe
	always_ff @(posedge F14M) begin
		if (RESET) begin
			video_addr <= '0;
			video_cs   <= 1'b0;
		end else begin
			if (xcnt[2:0] == 3'd7) begin
				if (hcnt == load_column)
					video_addr <= row_addr;
				else
					video_addr <= video_addr + 1'b1;
				video_cs <= 1'b1;
			end else if (xcnt[2:0] == 3'd3) begin
				video_cs <= 1'b0;  // ram byte taken
			end
		end
	end

	// data latches
	always_ff @(posedge F14M) begin
		if (xcnt[2:0] == 3'd3) begin
			ram_data     <= sdram_dout;
			charset_addr <= {{(CHARSET_AW - 11){1'b0}}, sdram_dout, ycnt[2:0]};
		end
		if (mode == MODE_TEXT40 && xcnt[3:0] == 4'd7)
			char_d <= charset_q;  // first byte of pair is the char
		if (mode == MODE_TEXT40 && xcnt[3:0] == 4'd15)
			fgbg <= ram_data;     // second byte is the attribute
	end

	// shifter and pixel out
	always_ff @(posedge F14M) begin
		if (RESET) begin
			pixel <= '0;
		end else if (in_blank) begin
			pixel <= '0;
		end else if (in_border) begin
			pixel <= border_color;
		end else if (mode != MODE_TEXT40 || !xcnt[0]) begin
			pixel <= char_sr[0] ? fg : bg;  // text40 holds every pixel twice
		end
	end

	always_ff @(posedge F14M) begin
		if (!in_blank && !in_border && (mode != MODE_TEXT40 || !xcnt[0]))
			char_sr <= char_sr >> 1;
		// reload wins over the last shift
		case (mode)
			MODE_TEXT80: if (xcnt[2:0] == 3'd7) char_sr <= charset_q;
			MODE_GR5:    if (xcnt[2:0] == 3'd7) char_sr <= ram_data;
			default:     if (xcnt[3:0] == 4'd15) char_sr <= char_d;
		endcase
	end

endmodule

`default_nettype wire

//--- source/vtl_palette.sv
/* 16 colour palette, index to 6-bit r, g, b */
`timescale 1ns/1ps
`default_nettype none

module vtl_palette import vtl_video_pkg::*; (
	input  color_idx_t pixel,
	output logic [5:0] r,
	output logic [5:0] g,
	output logic [5:0] b
);

	logic [11:0] rgb;

	assign rgb = PALETTE[pixel];

	// 4-bit guns into the upper bits of the dac
	assign r = {rgb[11:8], 2'b00};
	assign g = {rgb[7:4], 2'b00};
	assign b = {rgb[3:0], 2'b00};

endmodule

`default_nettype wire

//--- source/vtl_chip.sv
/* Laser 500 video and bus chip, top level */
`timescale 1ns/1ps
`default_nettype none

module vtl_chip import vtl_video_pkg::*, vtl_bus_pkg::*; (
	input  logic                  F14M,
	input  logic                  RESET,
	// z80 side
	input  logic                  MREQ_n,
	input  logic                  IORQ_n,
	input  logic                  RD_n,
	input  logic                  WR_n,
	input  logic [15:0]           A,
	input  logic [7:0]            DO,
	output logic [7:0]            DI,
	output logic                  CPUCK,
	output logic                  CPUENA,
	output logic                  WAIT_n,
	// sdram
	output logic [SDRAM_AW-1:0]   sdram_addr,
	input  logic [7:0]            sdram_dout,
	output logic [7:0]            sdram_din,
	output logic                  sdram_wr,
	output logic                  sdram_cs,
	// external charset rom, 1 cycle latency
	output logic [CHARSET_AW-1:0] charset_addr,
	input  logic [7:0]            charset_q,
	// crt
	output logic                  hsync,
	output logic                  vsync,
	output logic [5:0]            r,
	output logic [5:0]            g,
	output logic [5:0]            b
);

	logic [CNT_W-1:0]   hcnt, ycnt;
	logic               in_blank, in_border;
	page_t              banks [4];
	vdc_mode_e          mode;
	color_idx_t         border_color, text_fg, text_bg, pixel;
	logic               video_page_hi, cpu_io_write, video_cs;
	logic [VRAM_AW-1:0] video_addr;

	vtl_raster_counters i_raster (
		.F14M, .RESET, .hcnt, .vcnt(), .ycnt, .hsync, .vsync, .in_blank, .in_border
	);

	vtl_io_registers i_regs (
		.F14M, .RESET, .IORQ_n, .WR_n, .cpu_io_write, .A_low(A[7:0]), .DO,
		.banks, .mode, .border_color, .text_fg, .text_bg, .video_page_hi
	);

	vtl_bus_arbiter i_arbiter (
		.F14M, .RESET, .MREQ_n, .IORQ_n, .RD_n, .WR_n, .A, .DO, .banks,
		.video_page_hi, .video_addr, .video_cs, .sdram_dout,
		.CPUCK, .CPUENA, .WAIT_n, .DI, .cpu_io_write,
		.sdram_addr, .sdram_din, .sdram_wr, .sdram_cs
	);

	vtl_pixel_fetch i_fetch (
		.F14M, .RESET, .hcnt, .ycnt, .in_blank, .in_border, .mode,
		.border_color, .text_fg, .text_bg, .sdram_dout, .charset_q,
		.video_addr, .video_cs, .charset_addr, .pixel
	);

	vtl_palette i_palette (
		.pixel, .r, .g, .b
	);

endmodule

`default_nettype wire

//--- tests/vtl_chip_checker.sv
/* testbench checker for the Laser 500 video chip
   watches the DUT ports and compares them with reference values */
`timescale 1ns/1ps
`default_nettype none

module vtl_chip_checker import vtl_video_pkg::*, vtl_bus_pkg::*; (
	input  logic                F14M,
	input  logic                RESET,
	input  logic                hsync,
	input  logic                vsync,
	input  logic [5:0]          r,
	input  logic [5:0]          g,
	input  logic [5:0]          b,
	input  logic                CPUCK,
	input  logic                CPUENA,
	input  logic                WAIT_n,
	input  logic [7:0]          DI,
	input  logic [SDRAM_AW-1:0] sdram_addr,
	input  logic [7:0]          sdram_din,
	input  logic                sdram_wr,
	input  logic                sdram_cs,
	input  logic [CHARSET_AW-1:0] charset_addr,
	input  logic                MREQ_n,
	input  logic                RD_n,
	input  logic                WR_n,
	input  logic [15:0]         A,
	input  logic [7:0]          DO,
	input  logic [1:0]          phase,        // 1 text40, 2 text80, 3 gr5
	input  color_idx_t          exp_border,
	input  color_idx_t          exp_fg,
	input  color_idx_t          exp_bg,
	input  page_t               exp_page,     // page written to bank 1
	input  logic [7:0]          ram_byte
);

	int errs [1:6];
	int checks [1:6];
	int frames = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int hpos = 0;    // mirrors hcnt
	int vpos = 0;
	int ph = 0;      // position the current rgb belongs to
	int pv = 0;
	logic [2:0] slot = '0;
	logic hs_q, vs_q, wait_q, ena_seen, after_reset;
	int hcyc, hlow, vlines, vlow, wait_len, ena_cnt, fg_cnt, bg_cnt;
	logic [17:0] rgb;

	initial begin
		for (int i = 1; i <= 6; i++) begin
			errs[i] = 0;
			checks[i] = 0;
		end
		fg_cnt = 0;
		bg_cnt = 0;
	end

	// 4-bit guns padded to 6 bits
	function automatic logic [17:0] expected_rgb(input color_idx_t idx);
		logic [11:0] c;
		c = PALETTE[idx];
		return {c[11:8], 2'b00, c[7:4], 2'b00, c[3:0], 2'b00};
	endfunction

	function automatic logic [SDRAM_AW-1:0] expected_cpu_addr(input page_t page,
		input logic [15:0] addr);
		return {{(SDRAM_AW - 18){1'b0}}, page, addr[13:0]};
	endfunction

	// 0 blanking, 1 border, 2 active
	function automatic int region(input int h, input int v);
		if (h < H_SW + H_BP || h >= H_SW + H_BP + H_VISIBLE || v < V_SYNC_LINES)
			return 0;
		if (v < TOP_BORDER || v >= TOP_BORDER + ACTIVE_HEIGHT)
			return 1;
		if (h < ACTIVE_START || h >= ACTIVE_START + ACTIVE_WIDTH)
			return 1;
		return 2;
	endfunction

	task automatic compare(input int t, input string sig, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		checks[t]++;
		if (exp_v !== got_v) begin
			errs[t]++;
			if (errs[t] <= 10)  // keep the log readable
				$display("MISMATCH %s expected 0x%0h got 0x%0h at %0t", sig, exp_v, got_v, $time);
		end
	endtask

	task automatic report_test(input int t, input string name);
		tests_run++;
		if (checks[t] == 0) begin
			tests_failed++;
			$display("test %0d %s: FAIL, nothing was checked", t, name);
		end else if (errs[t] != 0) begin
			tests_failed++;
			$display("test %0d %s: FAIL, %0d errors in %0d checks", t, name, errs[t], checks[t]);
		end else begin
			$display("test %0d %s: PASS, %0d checks", t, name, checks[t]);
		end
	endtask

	task automatic report_totals();
		$display("tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
	endtask

	// position and slot mirrors, same stepping as the raster and slot counters
	always @(posedge F14M) begin
		ph <= hpos;
		pv <= vpos;
		if (RESET) begin
			hpos <= 0;
			vpos <= 0;
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
			if (hpos == H_TOTAL - 1) begin
				hpos <= 0;
				vpos <= (vpos == V_TOTAL - 1) ? 0 : vpos + 1;
			end else begin
				hpos <= hpos + 1;
			end
		end
	end

	always @(negedge F14M) begin
		rgb = {r, g, b};
		if (RESET) begin
			hcyc = 0;      // reset sits at hcnt 0 of line 0
			hlow = 0;
			vlines = 1;
			vlow = 1;
			hs_q = 1'b0;
			vs_q = 1'b0;
			wait_q = 1'b1;
			wait_len = 0;
			ena_cnt = 0;
			ena_seen = 1'b0;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				checks[6]++;
				if (!WAIT_n) begin
					errs[6]++;
					$display("WAIT_n is low right after reset at %0t", $time);
				end
				after_reset = 1'b0;
			end
			// sync timing between falling edges
			if (hs_q && !hsync) begin
				compare(1, "hsync period", H_TOTAL, hcyc);
				compare(1, "hsync low", H_SW, hlow);
				hcyc = 1;
				hlow = 1;
				if (vs_q && !vsync) begin
					compare(1, "vsync period lines", V_TOTAL, vlines);
					compare(1, "vsync low lines", V_SYNC_LINES, vlow);
					frames++;
					vlines = 1;
					vlow = 1;
				end else begin
					vlines++;
					if (!vsync)
						vlow++;
				end
				vs_q = vsync;
			end else begin
				hcyc++;
				if (!hsync)
					hlow++;
			end
			hs_q = hsync;
			// cpu enable every 8th cycle
			if (CPUENA) begin
				if (ena_seen)
					compare(6, "CPUENA period", 8, ena_cnt);
				ena_cnt = 1;
				ena_seen = 1'b1;
			end else begin
				ena_cnt++;
			end
			compare(6, "CPUCK", slot[1], CPUCK);  // F14M / 4
			// wait state length and read data
			if (!WAIT_n) begin
				wait_len++;
				compare(5, "sdram_cs", 1'b1, sdram_cs);  // cpu slots 4..7
				if (!WR_n)
					compare(5, "sdram_din", DO, sdram_din);
			end
			if (WAIT_n && !wait_q) begin
				compare(5, "WAIT_n low cycles", 4, wait_len);
				if (!MREQ_n && !RD_n)
					compare(5, "DI", ram_byte, DI);
				wait_len = 0;
			end
			wait_q = WAIT_n;
			// cpu half of the slot, bank 1 accesses
			if (slot[2] && !MREQ_n && A[15:14] == 2'b01) begin
				compare(5, "sdram_addr", expected_cpu_addr(exp_page, A), sdram_addr);
				compare(5, "sdram_wr", !WR_n && exp_page >= 4 && exp_page <= 7, sdram_wr);
			end
			// pixels
			if (phase != 2'd0) begin
				case (region(ph, pv))
					0: compare(2, "rgb blank", expected_rgb(4'd0), rgb);
					1: compare(2, "rgb border", expected_rgb(exp_border), rgb);
					default: begin
						if (phase == 2'd1)
							compare(3, "rgb text40", expected_rgb(ram_byte[7:4]), rgb);
						else if (phase == 2'd2)
							compare(3, "rgb text80", expected_rgb(exp_fg), rgb);
						else if (rgb == expected_rgb(exp_fg))
							fg_cnt++;
						else if (rgb == expected_rgb(exp_bg))
							bg_cnt++;
						else
							compare(4, "rgb gr5", expected_rgb(exp_fg), rgb);
					end
				endcase
				// char code from ram, glyph row from the line in the active area
				if ((phase == 2'd1 || phase == 2'd2) && region(ph, pv) == 2)
					compare(3, "charset_addr", {2'b00, ram_byte, 3'(pv - TOP_BORDER)},
						charset_addr);
				// end of an active line in gr5
				if (phase == 2'd3 && ph == ACTIVE_START + ACTIVE_WIDTH - 1
					&& region(ph, pv) == 2) begin
					compare(4, "gr5 fg count", ACTIVE_WIDTH / 2, fg_cnt);
					compare(4, "gr5 bg count", ACTIVE_WIDTH / 2, bg_cnt);
					fg_cnt = 0;
					bg_cnt = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/vtl_chip_tb.sv
/* testbench for the Laser 500 video chip
   clock, reset, SDRAM and charset models, CPU stimulus */
`timescale 1ns/1ps
`default_nettype none

module vtl_chip_tb import vtl_video_pkg::*, vtl_bus_pkg::*; ();

	localparam int CYCLE_LIMIT = 3 * H_TOTAL * V_TOTAL + 2000;  // three frames

	logic F14M, RESET, MREQ_n, IORQ_n, RD_n, WR_n;
	logic [15:0] A;
	logic [7:0] DO, DI, sdram_dout, sdram_din, charset_q;
	logic CPUCK, CPUENA, WAIT_n, sdram_wr, sdram_cs, hsync, vsync;
	logic [SDRAM_AW-1:0] sdram_addr;
	logic [CHARSET_AW-1:0] charset_addr;
	logic [5:0] r, g, b;
	logic [7:0] ram_byte, charset_byte;  // constant memory contents
	logic [1:0] phase;
	color_idx_t exp_border, exp_fg, exp_bg;
	page_t exp_page;
	logic [15:0] addr;
	integer seed;
	int cycles = 0;

	vtl_chip i_dut (
		.F14M, .RESET, .MREQ_n, .IORQ_n, .RD_n, .WR_n, .A, .DO, .DI,
		.CPUCK, .CPUENA, .WAIT_n, .sdram_addr, .sdram_dout, .sdram_din,
		.sdram_wr, .sdram_cs, .charset_addr, .charset_q,
		.hsync, .vsync, .r, .g, .b
	);

	vtl_chip_checker i_checker (
		.F14M, .RESET, .hsync, .vsync, .r, .g, .b, .CPUCK, .CPUENA, .WAIT_n, .DI,
		.sdram_addr, .sdram_din, .sdram_wr, .sdram_cs, .charset_addr,
		.MREQ_n, .RD_n, .WR_n, .A, .DO, .phase,
		.exp_border, .exp_fg, .exp_bg, .exp_page, .ram_byte
	);

	initial begin
		F14M = 1'b0;
		forever #10 F14M = ~F14M;
	end

	// sdram and charset rom, one cycle read latency
	always @(posedge F14M) begin
		sdram_dout <= ram_byte;
		charset_q  <= charset_byte;
	end

	always @(posedge F14M) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge F14M);
		#2;
		A = {8'h00, port};
		DO = data;
		IORQ_n = 1'b0;
		WR_n = 1'b0;
		@(posedge F14M);  // register takes it here
		#2;
		IORQ_n = 1'b1;
		WR_n = 1'b1;
	endtask

	// memory cycle held until the wait state ends
	task automatic mem_access(input logic [15:0] adr, input logic [7:0] data,
		input logic write);
		@(posedge F14M);
		#2;
		A = adr;
		DO = data;
		MREQ_n = 1'b0;
		WR_n = !write;
		RD_n = write;
		while (WAIT_n)
			@(negedge F14M);
		while (!WAIT_n)
			@(negedge F14M);
		@(posedge F14M);
		#2;
		MREQ_n = 1'b1;
		WR_n = 1'b1;
		RD_n = 1'b1;
	endtask

	task automatic wait_frame();
		int n;
		n = i_checker.frames;
		while (i_checker.frames == n)
			@(posedge F14M);
	endtask

	initial begin
		seed = 39;
		RESET = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n = 1'b1;
		WR_n = 1'b1;
		A = '0;
		DO = '0;
		sdram_dout = '0;
		charset_q = '0;
		ram_byte = 8'h5A;      // attribute fg 5 in text40
		charset_byte = 8'hFF;
		phase = 2'd0;
		exp_border = 4'd9;
		exp_fg = 4'd15;
		exp_bg = 4'd1;
		exp_page = '0;
		repeat (2) @(posedge F14M);
		#2 RESET = 1'b0;

		// first frame: border, text40, cpu bus
		exp_border = color_idx_t'($random(seed));
		io_write(PORT_VDC_CTRL, {exp_border, 4'b0000});
		phase = 2'd1;
		exp_page = page_t'($random(seed));
		io_write(PORT_BANK1, {4'h0, exp_page});
		for (int i = 0; i < 4; i++) begin
			addr = {2'b01, 14'($random(seed))};
			mem_access(addr, 8'($random(seed)), 1'b1);
			mem_access(addr, 8'h00, 1'b0);
		end
		wait_frame();

		// second frame: text80
		exp_fg = color_idx_t'($random(seed));
		exp_bg = exp_fg ^ 4'h8;
		io_write(PORT_VDC_COLOR, {exp_fg, exp_bg});
		io_write(PORT_VDC_CTRL, {exp_border, 4'b0001});
		phase = 2'd2;
		wait_frame();
		i_checker.report_test(3, "text40 and text80");

		// third frame: gr5 through the mapped io bit
		io_write(PORT_BANK0, {4'h0, PAGE_MAPPED_IO});
		ram_byte = 8'h55;
		addr = {2'b00, MAPPED_IO_LO | (14'($random(seed)) & 14'h07FF)};
		mem_access(addr, 8'h08, 1'b1);
		phase = 2'd3;
		wait_frame();
		i_checker.report_test(4, "gr5 pixels");

		// these ran over all three frames
		i_checker.report_test(1, "sync timing");
		i_checker.report_test(2, "border and blanking");
		i_checker.report_test(5, "cpu bank access");
		i_checker.report_test(6, "cpu enable and wait after reset");

		i_checker.report_totals();
		if (i_checker.tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vtl_chip.f
source/vtl_video_pkg.sv
source/vtl_bus_pkg.sv
source/vtl_raster_counters.sv
source/vtl_io_registers.sv
source/vtl_bus_arbiter.sv
source/vtl_pixel_fetch.sv
source/vtl_palette.sv
source/vtl_chip.sv
tests/vtl_chip_checker.sv
tests/vtl_chip_tb.sv

//--- Bender.yml
package:
  name: vtl_chip

sources:
  - source/vtl_video_pkg.sv
  - source/vtl_bus_pkg.sv
  - source/vtl_raster_counters.sv
  - source/vtl_io_registers.sv
  - source/vtl_bus_arbiter.sv
  - source/vtl_pixel_fetch.sv
  - source/vtl_palette.sv
  - source/vtl_chip.sv
  - target: test
    files:
      - tests/vtl_chip_checker.sv
      - tests/vtl_chip_tb.sv
